// File: verilog/dbank_pkg.sv
package dbank_pkg;

  ////////////////////
  // Bank geometry
  ////////////////////

  // Interleaved SRAM macros
  localparam int N_SRAM = 4;
  // Low word address bits pick the macro
  localparam int SRAM_SEL_W = 2;
  // Row address inside one macro
  localparam int BLOCK_ADDR_W = 8;
  // Full word address of a command
  localparam int BNK_ADDR_W = SRAM_SEL_W + BLOCK_ADDR_W;

  ////////////////////
  // Data and command fields
  ////////////////////

  localparam int DATA_W = 32;
  // One mask bit per byte
  localparam int MASK_W = DATA_W / 8;
  localparam int ID_W = 2;
  // Beat count minus one
  localparam int LEN_W = 2;

  ////////////////////
  // Buffering
  ////////////////////

  // Read FIFO depth, equal to the starting read credit
  localparam int RD_FIFO_DEPTH = 4;
  localparam int RSP_FIFO_DEPTH = 2;
  localparam int CREDIT_W = $clog2(RD_FIFO_DEPTH + 1);

  // Read FIFO entry is {last, id, data}
  localparam int RD_ENTRY_W = 1 + ID_W + DATA_W;

endpackage

// File: verilog/dbank_fifo.sv
`timescale 1ns/1ps

module dbank_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 2
) (
  input  logic             clk,
  input  logic             rst_a,
  input  logic             push,
  input  logic             pop,
  input  logic [WIDTH-1:0] din,
  output logic             full,
  output logic             head_valid,
  output logic [WIDTH-1:0] head_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Push into a full FIFO or pop from an empty one is ignored
  assign do_push = push & !full;
  assign do_pop  = pop & head_valid;

  assign full       = (count == CNT_W'(DEPTH));
  assign head_valid = (count != '0);
  assign head_data  = mem[rd_ptr];

  always_ff @(posedge clk or posedge rst_a)
  begin
    if (rst_a)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= din;
  end

endmodule

// File: verilog/dbank_arbiter.sv
`timescale 1ns/1ps

module dbank_arbiter import dbank_pkg::*; (
  input  logic                    dbank_ctrl_clk,
  input  logic                    rst_a,
  input  logic                    rd_req,
  input  logic                    wr_req,
  input  logic                    rd_done,
  input  logic                    wr_done,
  output logic                    rd_gnt,
  output logic                    wr_gnt,
  input  logic [BLOCK_ADDR_W-1:0] rd_block_addr,
  input  logic [BLOCK_ADDR_W-1:0] wr_block_addr,
  output logic [BLOCK_ADDR_W-1:0] block_addr
);

  logic busy_r;
  logic own_wr_r;
  logic wr_pri_r;
  logic pick_wr;

  // Fresh pick when no burst holds the bank
  assign pick_wr = wr_req & (!rd_req | wr_pri_r);

  assign rd_gnt = busy_r ? !own_wr_r : (rd_req & !pick_wr);
  assign wr_gnt = busy_r ? own_wr_r : pick_wr;

  // Shared row address follows the owner
  assign block_addr = wr_gnt ? wr_block_addr : rd_block_addr;

  always_ff @(posedge dbank_ctrl_clk or posedge rst_a)
  begin
    if (rst_a)
    begin
      busy_r   <= 1'b0;
      own_wr_r <= 1'b0;
      wr_pri_r <= 1'b0;
    end
    else
    begin
      if (rd_done || wr_done)
      begin
        busy_r   <= 1'b0;
        // Other side goes first next time
        wr_pri_r <= rd_done;
      end
      else if (rd_gnt || wr_gnt)
        busy_r <= 1'b1;
      if (!busy_r)
        own_wr_r <= wr_gnt;
    end
  end

endmodule

// File: verilog/dbank_rd_ctrl.sv
`timescale 1ns/1ps

module dbank_rd_ctrl import dbank_pkg::*; (
  input  logic                    dbank_ctrl_clk,
  input  logic                    rst_a,
  // Read command channel
  input  logic                    rd_cmd_valid,
  input  logic [BNK_ADDR_W-1:0]   rd_cmd_addr,
  input  logic [ID_W-1:0]         rd_cmd_id,
  input  logic [LEN_W-1:0]        rd_cmd_len,
  output logic                    rd_cmd_accept,
  // Credit and arbitration
  input  logic                    credit_ok,
  input  logic                    rd_gnt,
  output logic                    rd_req,
  output logic                    rd_done,
  // SRAM side
  output logic [BLOCK_ADDR_W-1:0] rd_block_addr,
  output logic [N_SRAM-1:0]       bnk_rd_en,
  // Beat info aligned with returning data
  output logic                    beat_valid,
  output logic                    beat_last,
  output logic [ID_W-1:0]         beat_id,
  output logic [N_SRAM-1:0]       beat_sel
);

  logic [LEN_W-1:0]      beat_cnt;
  logic [BNK_ADDR_W-1:0] beat_addr;
  logic [N_SRAM-1:0]     sel_onehot;
  logic                  issue;
  logic                  last;

  ////////////////////
  // Beat address
  ////////////////////

  // Wraps modulo the bank size
  assign beat_addr     = rd_cmd_addr + BNK_ADDR_W'(beat_cnt);
  assign sel_onehot    = N_SRAM'(1) << beat_addr[SRAM_SEL_W-1:0];
  assign rd_block_addr = beat_addr[BNK_ADDR_W-1:SRAM_SEL_W];

  // One beat per granted cycle, held off without credit
  assign rd_req = rd_cmd_valid & credit_ok;
  assign issue  = rd_req & rd_gnt;
  assign last   = (beat_cnt == rd_cmd_len);

  assign bnk_rd_en     = issue ? sel_onehot : '0;
  assign rd_done       = issue & last;
  assign rd_cmd_accept = rd_done;

  always_ff @(posedge dbank_ctrl_clk or posedge rst_a)
  begin
    if (rst_a)
    begin
      beat_cnt   <= '0;
      beat_valid <= 1'b0;
    end
    else
    begin
      beat_valid <= issue;
      if (issue)
        beat_cnt <= last ? '0 : beat_cnt + 1'b1;
    end
  end

  // Payload of the beat, valid alongside beat_valid
  always_ff @(posedge dbank_ctrl_clk)
  begin
    if (issue)
    begin
      beat_last <= last;
      beat_id   <= rd_cmd_id;
      beat_sel  <= sel_onehot;
    end
  end

endmodule

// File: verilog/dbank_wr_ctrl.sv
`timescale 1ns/1ps

module dbank_wr_ctrl import dbank_pkg::*; (
  input  logic                    dbank_ctrl_clk,
  input  logic                    rst_a,
  // Write command channel
  input  logic                    wr_cmd_valid,
  input  logic [BNK_ADDR_W-1:0]   wr_cmd_addr,
  input  logic [ID_W-1:0]         wr_cmd_id,
  input  logic [LEN_W-1:0]        wr_cmd_len,
  output logic                    wr_cmd_accept,
  // Write data channel
  input  logic                    wr_valid,
  input  logic [DATA_W-1:0]       wr_data,
  input  logic [MASK_W-1:0]       wr_mask,
  output logic                    wr_accept,
  // Arbitration and response FIFO state
  input  logic                    wr_gnt,
  input  logic                    rsp_full,
  output logic                    wr_req,
  output logic                    wr_done,
  // SRAM side
  output logic [BLOCK_ADDR_W-1:0] wr_block_addr,
  output logic [N_SRAM-1:0]       bnk_wr_en,
  output logic [DATA_W-1:0]       bnk_wr_data,
  output logic [MASK_W-1:0]       bnk_wr_mask,
  // Response push
  output logic                    rsp_push,
  output logic [ID_W-1:0]         rsp_id
);

  logic [LEN_W-1:0]      beat_cnt;
  logic [BNK_ADDR_W-1:0] beat_addr;
  logic [N_SRAM-1:0]     sel_onehot;
  logic                  issue;
  logic                  last;

  ////////////////////
  // Beat address
  ////////////////////

  assign beat_addr     = wr_cmd_addr + BNK_ADDR_W'(beat_cnt);
  assign sel_onehot    = N_SRAM'(1) << beat_addr[SRAM_SEL_W-1:0];
  assign wr_block_addr = beat_addr[BNK_ADDR_W-1:SRAM_SEL_W];

  // Needs command, data and room for the response
  assign wr_req = wr_cmd_valid & wr_valid & !rsp_full;
  assign issue  = wr_req & wr_gnt;
  assign last   = (beat_cnt == wr_cmd_len);

  ////////////////////
  // SRAM write beat
  ////////////////////

  assign bnk_wr_en   = issue ? sel_onehot : '0;
  assign bnk_wr_data = wr_data;
  assign bnk_wr_mask = wr_mask;

  // Data beat is consumed with the SRAM write
  assign wr_accept = issue;

  // Command retires and response is queued on the last beat
  assign wr_done       = issue & last;
  assign wr_cmd_accept = wr_done;
  assign rsp_push      = wr_done;
  assign rsp_id        = wr_cmd_id;

  always_ff @(posedge dbank_ctrl_clk or posedge rst_a)
  begin
    if (rst_a)
    begin
      beat_cnt <= '0;
    end
    else if (issue)
    begin
      beat_cnt <= last ? '0 : beat_cnt + 1'b1;
    end
  end

endmodule

// File: verilog/dbank_rd_return.sv
`timescale 1ns/1ps

module dbank_rd_return import dbank_pkg::*; (
  input  logic              dbank_ctrl_clk,
  input  logic              rst_a,
  input  logic              rd_issue,
  input  logic              beat_valid,
  input  logic              beat_last,
  input  logic [ID_W-1:0]   beat_id,
  input  logic [N_SRAM-1:0] beat_sel,
  input  logic [DATA_W-1:0] bnk_rd_data [N_SRAM],
  // Read data channel
  input  logic              rd_accept,
  output logic              rd_valid,
  output logic [DATA_W-1:0] rd_data,
  output logic [ID_W-1:0]   rd_id,
  output logic              rd_last,
  // Status
  output logic              credit_ok,
  output logic              rd_empty
);

  logic [DATA_W-1:0]     sel_data;
  logic [RD_ENTRY_W-1:0] fifo_in;
  logic [RD_ENTRY_W-1:0] fifo_out;
  logic                  fifo_full;
  logic                  fifo_pop;
  logic [CREDIT_W-1:0]   credit_r;

  // Only the addressed macro contributes
  always_comb
  begin
    sel_data = '0;
    for (int i = 0; i < N_SRAM; i++)
      if (beat_sel[i])
        sel_data |= bnk_rd_data[i];
  end

  assign fifo_in  = {beat_last, beat_id, sel_data};
  assign fifo_pop = rd_accept & rd_valid;

  dbank_fifo #(
    .WIDTH (RD_ENTRY_W),
    .DEPTH (RD_FIFO_DEPTH)
  ) u_rd_fifo (
    .clk        (dbank_ctrl_clk),
    .rst_a      (rst_a),
    .push       (beat_valid & !fifo_full),
    .pop        (fifo_pop),
    .din        (fifo_in),
    .full       (fifo_full),
    .head_valid (rd_valid),
    .head_data  (fifo_out)
  );

  assign {rd_last, rd_id, rd_data} = fifo_out;

  ////////////////////
  // Read credit
  ////////////////////

  // One credit per FIFO entry, so issued beats always find room
  assign credit_ok = (credit_r != '0);
  // All credits home means no beat in flight and an empty FIFO
  assign rd_empty  = (credit_r == CREDIT_W'(RD_FIFO_DEPTH));

  always_ff @(posedge dbank_ctrl_clk or posedge rst_a)
  begin
    if (rst_a)
      credit_r <= CREDIT_W'(RD_FIFO_DEPTH);
    else if (rd_issue && !fifo_pop)
      credit_r <= credit_r - 1'b1;
    else if (fifo_pop && !rd_issue)
      credit_r <= credit_r + 1'b1;
  end

endmodule

// File: verilog/dbank_top.sv
`timescale 1ns/1ps

module dbank_top import dbank_pkg::*; (
  input  logic                    dbank_ctrl_clk,
  input  logic                    rst_a,
  // Read command channel
  input  logic                    rd_cmd_valid,
  input  logic [BNK_ADDR_W-1:0]   rd_cmd_addr,
  input  logic [ID_W-1:0]         rd_cmd_id,
  input  logic [LEN_W-1:0]        rd_cmd_len,
  output logic                    rd_cmd_accept,
  // Write command channel
  input  logic                    wr_cmd_valid,
  input  logic [BNK_ADDR_W-1:0]   wr_cmd_addr,
  input  logic [ID_W-1:0]         wr_cmd_id,
  input  logic [LEN_W-1:0]        wr_cmd_len,
  output logic                    wr_cmd_accept,
  // Write data channel
  input  logic                    wr_valid,
  input  logic [DATA_W-1:0]       wr_data,
  input  logic [MASK_W-1:0]       wr_mask,
  output logic                    wr_accept,
  // Read data channel
  output logic                    rd_valid,
  output logic [DATA_W-1:0]       rd_data,
  output logic [ID_W-1:0]         rd_id,
  output logic                    rd_last,
  input  logic                    rd_accept,
  // SRAM macros
  output logic [BLOCK_ADDR_W-1:0] block_addr,
  output logic [N_SRAM-1:0]       bnk_rd_en,
  input  logic [DATA_W-1:0]       bnk_rd_data [N_SRAM],
  output logic [N_SRAM-1:0]       bnk_wr_en,
  output logic [DATA_W-1:0]       bnk_wr_data,
  output logic [MASK_W-1:0]       bnk_wr_mask,
  // Write response channel
  output logic                    rsp_valid,
  output logic [ID_W-1:0]         rsp_id,
  input  logic                    rsp_accept,
  output logic                    dbank_idle
);

  logic                    rd_req;
  logic                    wr_req;
  logic                    rd_gnt;
  logic                    wr_gnt;
  logic                    rd_done;
  logic                    wr_done;
  logic [BLOCK_ADDR_W-1:0] rd_block_addr;
  logic [BLOCK_ADDR_W-1:0] wr_block_addr;
  logic                    credit_ok;
  logic                    rd_empty;
  logic                    beat_valid;
  logic                    beat_last;
  logic [ID_W-1:0]         beat_id;
  logic [N_SRAM-1:0]       beat_sel;
  logic                    rsp_full;
  logic                    rsp_push;
  logic [ID_W-1:0]         rsp_push_id;

  ////////////////////
  // Arbitration
  ////////////////////

  dbank_arbiter u_arbiter (
    .dbank_ctrl_clk (dbank_ctrl_clk),
    .rst_a          (rst_a),
    .rd_req         (rd_req),
    .wr_req         (wr_req),
    .rd_done        (rd_done),
    .wr_done        (wr_done),
    .rd_gnt         (rd_gnt),
    .wr_gnt         (wr_gnt),
    .rd_block_addr  (rd_block_addr),
    .wr_block_addr  (wr_block_addr),
    .block_addr     (block_addr)
  );

  ////////////////////
  // Read path
  ////////////////////

  dbank_rd_ctrl u_rd_ctrl (
    .dbank_ctrl_clk (dbank_ctrl_clk),
    .rst_a          (rst_a),
    .rd_cmd_valid   (rd_cmd_valid),
    .rd_cmd_addr    (rd_cmd_addr),
    .rd_cmd_id      (rd_cmd_id),
    .rd_cmd_len     (rd_cmd_len),
    .rd_cmd_accept  (rd_cmd_accept),
    .credit_ok      (credit_ok),
    .rd_gnt         (rd_gnt),
    .rd_req         (rd_req),
    .rd_done        (rd_done),
    .rd_block_addr  (rd_block_addr),
    .bnk_rd_en      (bnk_rd_en),
    .beat_valid     (beat_valid),
    .beat_last      (beat_last),
    .beat_id        (beat_id),
    .beat_sel       (beat_sel)
  );

  dbank_rd_return u_rd_return (
    .dbank_ctrl_clk (dbank_ctrl_clk),
    .rst_a          (rst_a),
    .rd_issue       (|bnk_rd_en),
    .beat_valid     (beat_valid),
    .beat_last      (beat_last),
    .beat_id        (beat_id),
    .beat_sel       (beat_sel),
    .bnk_rd_data    (bnk_rd_data),
    .rd_accept      (rd_accept),
    .rd_valid       (rd_valid),
    .rd_data        (rd_data),
    .rd_id          (rd_id),
    .rd_last        (rd_last),
    .credit_ok      (credit_ok),
    .rd_empty       (rd_empty)
  );

  ////////////////////
  // Write path
  ////////////////////

  dbank_wr_ctrl u_wr_ctrl (
    .dbank_ctrl_clk (dbank_ctrl_clk),
    .rst_a          (rst_a),
    .wr_cmd_valid   (wr_cmd_valid),
    .wr_cmd_addr    (wr_cmd_addr),
    .wr_cmd_id      (wr_cmd_id),
    .wr_cmd_len     (wr_cmd_len),
    .wr_cmd_accept  (wr_cmd_accept),
    .wr_valid       (wr_valid),
    .wr_data        (wr_data),
    .wr_mask        (wr_mask),
    .wr_accept      (wr_accept),
    .wr_gnt         (wr_gnt),
    .rsp_full       (rsp_full),
    .wr_req         (wr_req),
    .wr_done        (wr_done),
    .wr_block_addr  (wr_block_addr),
    .bnk_wr_en      (bnk_wr_en),
    .bnk_wr_data    (bnk_wr_data),
    .bnk_wr_mask    (bnk_wr_mask),
    .rsp_push       (rsp_push),
    .rsp_id         (rsp_push_id)
  );

  // Response skid FIFO
  dbank_fifo #(
    .WIDTH (ID_W),
    .DEPTH (RSP_FIFO_DEPTH)
  ) u_rsp_fifo (
    .clk        (dbank_ctrl_clk),
    .rst_a      (rst_a),
    .push       (rsp_push),
    .pop        (rsp_accept),
    .din        (rsp_push_id),
    .full       (rsp_full),
    .head_valid (rsp_valid),
    .head_data  (rsp_id)
  );

  // Commands stay valid until their last beat, so they cover bursts in flight
  assign dbank_idle = !rd_cmd_valid & !wr_cmd_valid & !wr_valid & rd_empty & !rsp_valid;

endmodule

// File: testbench/tb_sram_model.sv
`timescale 1ns/1ps

module tb_sram_model import dbank_pkg::*; (
  input  logic                    clk,
  input  logic [BLOCK_ADDR_W-1:0] block_addr,
  input  logic [N_SRAM-1:0]       rd_en,
  output logic [DATA_W-1:0]       rd_data [N_SRAM],
  input  logic [N_SRAM-1:0]       wr_en,
  input  logic [DATA_W-1:0]       wr_data,
  input  logic [MASK_W-1:0]       wr_mask
);

  localparam int ROWS = 1 << BLOCK_ADDR_W;

  logic [DATA_W-1:0] mem [N_SRAM][ROWS];

  // Fill word carries the full word address, row times macros plus macro
  initial
  begin
    for (int m = 0; m < N_SRAM; m++)
    begin
      rd_data[m] = '0;
      for (int r = 0; r < ROWS; r++)
        mem[m][r] = 32'hc0de_0000 | DATA_W'(r * N_SRAM + m);
    end
  end

  // One cycle read latency, byte masked writes
  always @(posedge clk)
  begin
    for (int m = 0; m < N_SRAM; m++)
    begin
      if (rd_en[m])
        rd_data[m] <= mem[m][block_addr];
      if (wr_en[m])
        for (int b = 0; b < MASK_W; b++)
          if (wr_mask[b])
            mem[m][block_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
    end
  end

endmodule

// File: testbench/tb_dbank.sv
`timescale 1ns/1ps

module tb_dbank import dbank_pkg::*; ();

  localparam int WAIT_LIMIT = 400;
  // Expected read beat is {last, id, data}
  localparam int EXP_W = 1 + ID_W + DATA_W;

  logic                    dbank_ctrl_clk;
  logic                    rst_a;
  logic                    rd_cmd_valid;
  logic [BNK_ADDR_W-1:0]   rd_cmd_addr;
  logic [ID_W-1:0]         rd_cmd_id;
  logic [LEN_W-1:0]        rd_cmd_len;
  logic                    rd_cmd_accept;
  logic                    wr_cmd_valid;
  logic [BNK_ADDR_W-1:0]   wr_cmd_addr;
  logic [ID_W-1:0]         wr_cmd_id;
  logic [LEN_W-1:0]        wr_cmd_len;
  logic                    wr_cmd_accept;
  logic                    wr_valid;
  logic [DATA_W-1:0]       wr_data;
  logic [MASK_W-1:0]       wr_mask;
  logic                    wr_accept;
  logic                    rd_valid;
  logic [DATA_W-1:0]       rd_data;
  logic [ID_W-1:0]         rd_id;
  logic                    rd_last;
  logic                    rd_accept;
  logic [BLOCK_ADDR_W-1:0] block_addr;
  logic [N_SRAM-1:0]       bnk_rd_en;
  logic [DATA_W-1:0]       bnk_rd_data [N_SRAM];
  logic [N_SRAM-1:0]       bnk_wr_en;
  logic [DATA_W-1:0]       bnk_wr_data;
  logic [MASK_W-1:0]       bnk_wr_mask;
  logic                    rsp_valid;
  logic [ID_W-1:0]         rsp_id;
  logic                    rsp_accept;
  logic                    dbank_idle;

  int                      seed;
  logic [EXP_W-1:0]        rd_exp_q [$];
  logic [ID_W-1:0]         rsp_exp_q [$];

  dbank_top dut0 (.*);

  tb_sram_model u_sram (
    .clk        (dbank_ctrl_clk),
    .block_addr (block_addr),
    .rd_en      (bnk_rd_en),
    .rd_data    (bnk_rd_data),
    .wr_en      (bnk_wr_en),
    .wr_data    (bnk_wr_data),
    .wr_mask    (bnk_wr_mask)
  );

  initial
  begin
    dbank_ctrl_clk = 1'b0;
    forever #20 dbank_ctrl_clk = ~dbank_ctrl_clk;
  end

  task automatic report_mismatch(input string what);
    $display("[FAIL] %0t ns: %s", $time, what);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic abort_run(input string what);
    $display("Run stopped: %s", what);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  ////////////////////
  // Command drivers
  ////////////////////

  // Beat k writes data+k at addr+k
  task automatic write_burst(input logic [BNK_ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                             input logic [LEN_W-1:0] len, input logic [DATA_W-1:0] data,
                             input logic [MASK_W-1:0] mask);
    int beats;
    int n;
    beats = int'(len) + 1;
    rsp_exp_q.push_back(id);
    @(posedge dbank_ctrl_clk);
    wr_cmd_valid <= 1'b1;
    wr_cmd_addr  <= addr;
    wr_cmd_id    <= id;
    wr_cmd_len   <= len;
    for (int k = 0; k < beats; k++)
    begin
      wr_valid <= 1'b1;
      wr_data  <= data + DATA_W'(k);
      wr_mask  <= mask;
      n = 0;
      do
      begin
        @(negedge dbank_ctrl_clk);
        n++;
        if (n > WAIT_LIMIT)
          abort_run($sformatf("write beat %0d to %h was never accepted", k, addr));
      end
      while (!wr_accept);
      // Command retires with its last data beat only
      assert (wr_cmd_accept == (k == beats - 1))
      else
        report_mismatch($sformatf("wr_cmd_accept is %b on write beat %0d", wr_cmd_accept, k));
      // A pending command keeps the bank busy
      assert (!dbank_idle)
      else
        report_mismatch($sformatf("dbank_idle is high during write beat %0d", k));
      @(posedge dbank_ctrl_clk);
    end
    wr_cmd_valid <= 1'b0;
    wr_valid     <= 1'b0;
  endtask

  // Beat k is expected to return first_word+k
  task automatic read_burst(input logic [BNK_ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                            input logic [LEN_W-1:0] len, input logic [DATA_W-1:0] first_word);
    int beats;
    int n;
    beats = int'(len) + 1;
    for (int k = 0; k < beats; k++)
      rd_exp_q.push_back({k == beats - 1, id, first_word + DATA_W'(k)});
    @(posedge dbank_ctrl_clk);
    rd_cmd_valid <= 1'b1;
    rd_cmd_addr  <= addr;
    rd_cmd_id    <= id;
    rd_cmd_len   <= len;
    n = 0;
    do
    begin
      @(negedge dbank_ctrl_clk);
      n++;
      if (n > WAIT_LIMIT)
        abort_run($sformatf("read command to %h was never accepted", addr));
    end
    while (!rd_cmd_accept);
    assert (!dbank_idle)
    else
      report_mismatch($sformatf("dbank_idle is high while read to %h is pending", addr));
    @(posedge dbank_ctrl_clk);
    rd_cmd_valid <= 1'b0;
  endtask

  ////////////////////
  // Output monitor
  ////////////////////

  // Random accept stalls, checks on read beats and write responses
  task automatic watch_outputs();
    logic [31:0]      r;
    logic [EXP_W-1:0] got;
    logic [EXP_W-1:0] want;
    logic [EXP_W-1:0] held;
    logic             held_ok;
    logic [ID_W-1:0]  want_id;
    held_ok = 1'b0;
    forever
    begin
      @(posedge dbank_ctrl_clk);
      r = $random(seed);
      rd_accept  <= r[0] | r[1];
      rsp_accept <= r[2] | r[3];
      @(negedge dbank_ctrl_clk);
      got = {rd_last, rd_id, rd_data};
      assert (rd_valid || !held_ok)
      else
        report_mismatch($sformatf("stalled read beat %h vanished", held));
      if (rd_valid)
      begin
        if (held_ok)
        begin
          assert (got == held)
          else
            report_mismatch($sformatf("stalled read beat changed from %h to %h", held, got));
        end
        if (rd_accept)
        begin
          assert (rd_exp_q.size() > 0)
          else
            report_mismatch($sformatf("unexpected read beat %h", got));
          want = rd_exp_q.pop_front();
          assert (got == want)
          else
            report_mismatch($sformatf("read beat %h, expected %h", got, want));
          held_ok = 1'b0;
        end
        else
        begin
          held    = got;
          held_ok = 1'b1;
        end
      end
      if (rsp_valid && rsp_accept)
      begin
        assert (rsp_exp_q.size() > 0)
        else
          report_mismatch($sformatf("unexpected write response id %0d", rsp_id));
        want_id = rsp_exp_q.pop_front();
        assert (rsp_id == want_id)
        else
          report_mismatch($sformatf("write response id %0d, expected %0d", rsp_id, want_id));
      end
    end
  endtask

  initial
  begin
    int                    fd;
    int                    fields;
    int                    n;
    string                 line;
    logic [7:0]            op;
    logic [BNK_ADDR_W-1:0] v_addr;
    logic [ID_W-1:0]       v_id;
    logic [LEN_W-1:0]      v_len;
    logic [DATA_W-1:0]     v_data;
    logic [MASK_W-1:0]     v_mask;
    logic [DATA_W-1:0]     v_word;
    logic                  pair_open;
    logic [BNK_ADDR_W-1:0] c_addr;
    logic [ID_W-1:0]       c_id;
    logic [LEN_W-1:0]      c_len;
    logic [DATA_W-1:0]     c_data;
    logic [MASK_W-1:0]     c_mask;

    seed         = 32'h9676_c967;
    rst_a        = 1'b1;
    rd_cmd_valid = 1'b0;
    rd_cmd_addr  = '0;
    rd_cmd_id    = '0;
    rd_cmd_len   = '0;
    wr_cmd_valid = 1'b0;
    wr_cmd_addr  = '0;
    wr_cmd_id    = '0;
    wr_cmd_len   = '0;
    wr_valid     = 1'b0;
    wr_data      = '0;
    wr_mask      = '0;
    rd_accept    = 1'b0;
    rsp_accept   = 1'b0;

    repeat (4) @(posedge dbank_ctrl_clk);
    rst_a <= 1'b0;
    @(negedge dbank_ctrl_clk);
    assert (!(rd_cmd_accept | wr_cmd_accept | wr_accept | rd_valid | rsp_valid |
              (|bnk_rd_en) | (|bnk_wr_en)) && dbank_idle)
    else
      report_mismatch("outputs after reset are not idle");

    fork
      watch_outputs();
    join_none

    fd = $fopen("testbench/dbank_vectors.txt", "r");
    if (fd == 0)
      abort_run("cannot open testbench/dbank_vectors.txt");

    // A C record waits for the next R record and runs alongside it
    pair_open = 1'b0;
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() < 2 || line[0] == "#")
        continue;
      fields = $sscanf(line, "%c %h %h %h %h %h %h",
                       op, v_addr, v_id, v_len, v_data, v_mask, v_word);
      if (fields != 7)
        abort_run($sformatf("malformed vector line: %s", line));
      if (op == "C")
      begin
        c_addr    = v_addr;
        c_id      = v_id;
        c_len     = v_len;
        c_data    = v_data;
        c_mask    = v_mask;
        pair_open = 1'b1;
      end
      else if (op == "W")
        write_burst(v_addr, v_id, v_len, v_data, v_mask);
      else if (op == "R" && pair_open)
      begin
        fork
          write_burst(c_addr, c_id, c_len, c_data, c_mask);
          read_burst(v_addr, v_id, v_len, v_word);
        join
        pair_open = 1'b0;
      end
      else if (op == "R")
        read_burst(v_addr, v_id, v_len, v_word);
      else
        abort_run($sformatf("unknown operation in vector line: %s", line));
    end
    $fclose(fd);

    // Drain outstanding beats and responses
    n = 0;
    while ((rd_exp_q.size() != 0 || rsp_exp_q.size() != 0 || !dbank_idle) && n < WAIT_LIMIT)
    begin
      @(negedge dbank_ctrl_clk);
      n++;
    end
    if (rd_exp_q.size() == 0 && rsp_exp_q.size() == 0 && dbank_idle)
    begin
      $display("PASS: all tests");
      $finish;
    end
    else
    begin
      $display("Run stopped: %0d read beats and %0d write responses missing, idle is %b",
               rd_exp_q.size(), rsp_exp_q.size(), dbank_idle);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

endmodule

// File: testbench/dbank_vectors.txt
# op addr id len data mask expect, all hex; W write, R read, C write run with the next R
# Write beat k carries data+k, read beat k expects expect+k
W 010 1 0 11223344 5 00000000
R 010 1 0 00000000 0 c0220044
W 021 2 0 aabbccdd a 00000000
R 021 2 0 00000000 0 aadecc21
W 032 3 0 55667788 f 00000000
W 033 0 0 ffffffff 0 00000000
R 032 3 0 00000000 0 55667788
R 033 0 0 00000000 0 c0de0033
R 105 1 3 00000000 0 c0de0105
R 0ff 2 3 00000000 0 c0de00ff
W 200 0 3 10000000 f 00000000
W 206 1 2 20000000 f 00000000
W 20b 2 1 30000000 3 00000000
W 210 3 0 40000000 f 00000000
R 200 0 3 00000000 0 10000000
R 206 1 2 00000000 0 20000000
R 20b 2 1 00000000 0 c0de0000
R 210 3 0 00000000 0 40000000
C 300 3 3 50000000 f 00000000
R 110 0 3 00000000 0 c0de0110
C 304 1 1 60000000 c 00000000
R 120 2 1 00000000 0 c0de0120
R 300 3 3 00000000 0 50000000
R 304 1 1 00000000 0 60000304

// File: tb.f
verilog/dbank_pkg.sv
verilog/dbank_fifo.sv
verilog/dbank_arbiter.sv
verilog/dbank_rd_ctrl.sv
verilog/dbank_wr_ctrl.sv
verilog/dbank_rd_return.sv
verilog/dbank_top.sv
testbench/tb_sram_model.sv
testbench/tb_dbank.sv

// File: Makefile
# Verilator build and run of the data bank testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run tb_dbank"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module tb_dbank -f tb.f -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_dbank)"; echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
